//--- src/dma_pkg.sv
// Shared widths, limits, modes and payload structs; imported by every DMA module and the testbench
package dma_pkg;

    // Bus geometry
    localparam int DATA_W         = 32;
    localparam int ADDR_W         = 32;
    localparam int BYTES_PER_BEAT = DATA_W / 8;
    localparam int ADDR_LSB       = 2;

    // Burst and buffer limits
    localparam int MAX_BURST_BEATS = 16;
    localparam int FIFO_DEPTH      = 32;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [7:0]        len_t;
    typedef logic [1:0]        resp_t;

    typedef enum logic {
        MODE_READ  = 1'b0,
        MODE_WRITE = 1'b1
    } dma_mode_t;

    // One command, length in bytes
    typedef struct packed {
        dma_mode_t         mode;
        addr_t             addr;
        logic [ADDR_W-1:0] length;
    } dma_cmd_t;

    typedef struct packed {
        logic              busy;
        logic              done;
        logic              error;
        logic [ADDR_W-1:0] bytes_xfer;
    } dma_status_t;

    // Controller to channel master, len is beats minus one
    typedef struct packed {
        addr_t addr;
        len_t  len;
    } burst_req_t;

    typedef struct packed {
        addr_t addr;
        len_t  len;
    } axi_addr_t;

    typedef struct packed {
        data_t data;
        resp_t resp;
        logic  last;
    } axi_r_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } axi_w_t;

endpackage

//--- src/dma_fifo.sv
// Circular word buffer with valid/ready on both sides; used as the read and the write buffer
`timescale 1ns/1ps

module dma_fifo (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  dma_pkg::data_t  push_data,
    output logic            push_ready,
    input  logic            pop,
    output dma_pkg::data_t  pop_data,
    output logic            pop_valid
);
    import dma_pkg::*;

    data_t mem [FIFO_DEPTH];

    // Extra top bit tells full from empty
    logic [$clog2(FIFO_DEPTH):0] wr_ptr;
    logic [$clog2(FIFO_DEPTH):0] rd_ptr;
    logic                        full;
    logic                        empty;
    logic                        do_push;
    logic                        do_pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[$clog2(FIFO_DEPTH)] != rd_ptr[$clog2(FIFO_DEPTH)]) &&
                   (wr_ptr[$clog2(FIFO_DEPTH)-1:0] == rd_ptr[$clog2(FIFO_DEPTH)-1:0]);

    assign push_ready = !full;
    assign pop_valid  = !empty;
    assign do_push    = push && push_ready;
    assign do_pop     = pop && pop_valid;

    assign pop_data = mem[rd_ptr[$clog2(FIFO_DEPTH)-1:0]];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[$clog2(FIFO_DEPTH)-1:0]] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

//--- src/dma_controller.sv
// Command sequencer: splits a transfer into bursts, hands them to a channel master, keeps status
`timescale 1ns/1ps

module dma_controller (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  dma_pkg::dma_cmd_t     cmd,
    output dma_pkg::dma_status_t  status,
    output dma_pkg::burst_req_t   burst,
    output logic                  rd_burst_start,
    output logic                  wr_burst_start,
    input  logic                  burst_done,
    input  logic                  burst_err
);
    import dma_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_PLAN,
        S_ISSUE,
        S_WAIT,
        S_ADVANCE,
        S_DONE,
        S_ERROR
    } state_t;

    state_t            state;
    dma_mode_t         mode_q;
    addr_t             cur_addr;
    logic [ADDR_W-1:0] remain_beats;
    logic [ADDR_W-1:0] bytes_q;
    len_t              burst_len;
    logic              error_q;
    logic [8:0]        burst_beats;

    assign burst_beats = {1'b0, burst_len} + 9'd1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            mode_q       <= MODE_READ;
            remain_beats <= '0;
            bytes_q      <= '0;
            error_q      <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        mode_q       <= cmd.mode;
                        remain_beats <= cmd.length >> ADDR_LSB;
                        bytes_q      <= '0;
                        error_q      <= 1'b0;
                        state        <= S_PLAN;
                    end
                end
                S_PLAN: begin
                    // Nothing left means the command is complete
                    if (remain_beats == '0) begin
                        state <= S_DONE;
                    end else begin
                        state <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    state <= S_WAIT;
                end
                S_WAIT: begin
                    if (burst_done) begin
                        if (burst_err) begin
                            error_q <= 1'b1;
                            state   <= S_ERROR;
                        end else begin
                            state <= S_ADVANCE;
                        end
                    end
                end
                S_ADVANCE: begin
                    remain_beats <= remain_beats - ADDR_W'(burst_beats);
                    bytes_q      <= bytes_q + (ADDR_W'(burst_beats) << ADDR_LSB);
                    state        <= S_PLAN;
                end
                default: begin
                    // Done and error last one cycle each
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Burst address and length
    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            cur_addr <= cmd.addr;
        end else if (state == S_ADVANCE) begin
            cur_addr <= cur_addr + (ADDR_W'(burst_beats) << ADDR_LSB);
        end
        if (state == S_PLAN) begin
            if (remain_beats > ADDR_W'(MAX_BURST_BEATS)) begin
                burst_len <= len_t'(MAX_BURST_BEATS - 1);
            end else begin
                burst_len <= len_t'(remain_beats - 1'b1);
            end
        end
    end

    assign burst.addr = cur_addr;
    assign burst.len  = burst_len;

    assign rd_burst_start = (state == S_ISSUE) && (mode_q == MODE_READ);
    assign wr_burst_start = (state == S_ISSUE) && (mode_q == MODE_WRITE);

    // busy drops on the same edge that done or error rises
    assign status.busy       = (state == S_PLAN) || (state == S_ISSUE) ||
                               (state == S_WAIT) || (state == S_ADVANCE);
    assign status.done       = (state == S_DONE);
    assign status.error      = error_q;
    assign status.bytes_xfer = bytes_q;

endmodule

//--- src/axi_read_master.sv
// AXI read channel master: one AR per burst, R beats flow into the read buffer
`timescale 1ns/1ps

module axi_read_master (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dma_pkg::burst_req_t  burst,
    input  logic                 burst_start,
    output dma_pkg::axi_addr_t   ar,
    output logic                 arvalid,
    input  logic                 arready,
    input  dma_pkg::axi_r_t      r,
    input  logic                 rvalid,
    output logic                 rready,
    output logic                 push,
    output dma_pkg::data_t       push_data,
    input  logic                 push_ready,
    output logic                 burst_done,
    output logic                 burst_err
);
    import dma_pkg::*;

    axi_addr_t ar_q;
    logic      data_open;
    logic      err_q;
    logic      beat_bad;

    assign ar     = ar_q;
    assign rready = data_open && push_ready;
    assign push   = rvalid && rready;

    // Bad beats are still buffered
    assign push_data = r.data;
    assign beat_bad  = (r.resp != RESP_OKAY);

    always_ff @(posedge clk) begin
        if (burst_start) begin
            ar_q.addr <= burst.addr;
            ar_q.len  <= burst.len;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid    <= 1'b0;
            data_open  <= 1'b0;
            err_q      <= 1'b0;
            burst_done <= 1'b0;
            burst_err  <= 1'b0;
        end else begin
            burst_done <= 1'b0;
            if (burst_start) begin
                arvalid <= 1'b1;
                err_q   <= 1'b0;
            end else if (arvalid && arready) begin
                arvalid   <= 1'b0;
                data_open <= 1'b1;
            end
            if (push) begin
                err_q <= err_q || beat_bad;
                if (r.last) begin
                    data_open  <= 1'b0;
                    burst_done <= 1'b1;
                    burst_err  <= err_q || beat_bad;
                end
            end
        end
    end

endmodule

//--- src/axi_write_master.sv
// AXI write channel master: AW, then buffered W beats with wlast, then the B response
`timescale 1ns/1ps

module axi_write_master (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dma_pkg::burst_req_t  burst,
    input  logic                 burst_start,
    output dma_pkg::axi_addr_t   aw,
    output logic                 awvalid,
    input  logic                 awready,
    output dma_pkg::axi_w_t      w,
    output logic                 wvalid,
    input  logic                 wready,
    input  dma_pkg::resp_t       b,
    input  logic                 bvalid,
    output logic                 bready,
    output logic                 pop,
    input  dma_pkg::data_t       pop_data,
    input  logic                 pop_valid,
    output logic                 burst_done,
    output logic                 burst_err
);
    import dma_pkg::*;

    typedef enum logic [1:0] {
        P_IDLE,
        P_ADDR,
        P_DATA,
        P_RESP
    } phase_t;

    phase_t    phase;
    axi_addr_t aw_q;
    len_t      beat_cnt;

    assign aw      = aw_q;
    assign awvalid = (phase == P_ADDR);
    assign bready  = (phase == P_RESP);

    // W beats come straight off the write buffer
    assign wvalid = (phase == P_DATA) && pop_valid;
    assign w.data = pop_data;
    assign w.last = (beat_cnt == aw_q.len);
    assign pop    = wvalid && wready;

    always_ff @(posedge clk) begin
        if (burst_start) begin
            aw_q.addr <= burst.addr;
            aw_q.len  <= burst.len;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= P_IDLE;
            beat_cnt   <= '0;
            burst_done <= 1'b0;
            burst_err  <= 1'b0;
        end else begin
            burst_done <= 1'b0;
            case (phase)
                P_IDLE: begin
                    if (burst_start) begin
                        beat_cnt <= '0;
                        phase    <= P_ADDR;
                    end
                end
                P_ADDR: begin
                    if (awready) begin
                        phase <= P_DATA;
                    end
                end
                P_DATA: begin
                    if (pop) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (w.last) begin
                            phase <= P_RESP;
                        end
                    end
                end
                default: begin
                    if (bvalid) begin
                        burst_done <= 1'b1;
                        burst_err  <= (b != RESP_OKAY);
                        phase      <= P_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

//--- src/axi_dma_top.sv
// DMA engine top level: controller, AXI read and write masters, read and write buffers
`timescale 1ns/1ps

module axi_dma_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  dma_pkg::dma_cmd_t     cmd,
    output dma_pkg::dma_status_t  status,
    output dma_pkg::data_t        rd_data,
    output logic                  rd_valid,
    input  logic                  rd_ready,
    input  dma_pkg::data_t        wr_data,
    input  logic                  wr_valid,
    output logic                  wr_ready,
    output dma_pkg::axi_addr_t    ar,
    output logic                  arvalid,
    input  logic                  arready,
    input  dma_pkg::axi_r_t       r,
    input  logic                  rvalid,
    output logic                  rready,
    output dma_pkg::axi_addr_t    aw,
    output logic                  awvalid,
    input  logic                  awready,
    output dma_pkg::axi_w_t       w,
    output logic                  wvalid,
    input  logic                  wready,
    input  dma_pkg::resp_t        b,
    input  logic                  bvalid,
    output logic                  bready
);
    import dma_pkg::*;

    burst_req_t burst;
    logic       rd_burst_start;
    logic       wr_burst_start;
    logic       rd_done;
    logic       rd_err;
    logic       wr_done;
    logic       wr_err;
    logic       rd_push;
    data_t      rd_push_data;
    logic       rd_push_ready;
    logic       wr_pop;
    data_t      wr_pop_data;
    logic       wr_pop_valid;

    dma_controller ctrl (
        .clk, .rst_n, .start, .cmd, .status, .burst,
        .rd_burst_start, .wr_burst_start,
        // Only one master runs per command
        .burst_done (rd_done || wr_done),
        .burst_err  (rd_err || wr_err)
    );

    axi_read_master rd_master (
        .clk, .rst_n, .burst, .burst_start (rd_burst_start),
        .ar, .arvalid, .arready, .r, .rvalid, .rready,
        .push (rd_push), .push_data (rd_push_data), .push_ready (rd_push_ready),
        .burst_done (rd_done), .burst_err (rd_err)
    );

    axi_write_master wr_master (
        .clk, .rst_n, .burst, .burst_start (wr_burst_start),
        .aw, .awvalid, .awready, .w, .wvalid, .wready, .b, .bvalid, .bready,
        .pop (wr_pop), .pop_data (wr_pop_data), .pop_valid (wr_pop_valid),
        .burst_done (wr_done), .burst_err (wr_err)
    );

    // Memory to core
    dma_fifo read_buf (
        .clk, .rst_n,
        .push (rd_push), .push_data (rd_push_data), .push_ready (rd_push_ready),
        .pop (rd_ready), .pop_data (rd_data), .pop_valid (rd_valid)
    );

    // Core to memory
    dma_fifo write_buf (
        .clk, .rst_n,
        .push (wr_valid), .push_data (wr_data), .push_ready (wr_ready),
        .pop (wr_pop), .pop_data (wr_pop_data), .pop_valid (wr_pop_valid)
    );

endmodule

//--- verif/axi_slave_model.sv
// Memory-backed AXI slave for the DMA testbench; answers SLVERR on one chosen burst per command
`timescale 1ns/1ps

module axi_slave_model (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                prepare,
    input  dma_pkg::data_t      pattern,
    input  int                  fail_burst,
    input  dma_pkg::axi_addr_t  ar,
    input  logic                arvalid,
    output logic                arready,
    output dma_pkg::axi_r_t     r,
    output logic                rvalid,
    input  logic                rready,
    input  dma_pkg::axi_addr_t  aw,
    input  logic                awvalid,
    output logic                awready,
    input  dma_pkg::axi_w_t     w,
    input  logic                wvalid,
    output logic                wready,
    output dma_pkg::resp_t      b,
    output logic                bvalid,
    input  logic                bready
);
    import dma_pkg::*;

    // 4 KB of word storage
    data_t      mem [1024];
    axi_addr_t  rd_q;
    axi_addr_t  wr_q;
    len_t       rd_beat;
    len_t       wr_beat;
    logic [9:0] rd_idx;
    logic [9:0] wr_idx;
    logic       rd_busy;
    logic       rd_bad;
    logic       wr_data_ph;
    logic       wr_resp_ph;
    logic       wr_bad;
    int         burst_idx;
    logic [1:0] stall_cnt;

    assign rd_idx  = rd_q.addr[11:2] + 10'(rd_beat);
    assign wr_idx  = wr_q.addr[11:2] + 10'(wr_beat);
    // Ready drops now and then on AR, AW and W
    assign arready = !rd_busy && stall_cnt[0];
    assign rvalid  = rd_busy;
    assign r.data  = mem[rd_idx];
    // 2'b10 is SLVERR
    assign r.resp  = rd_bad ? resp_t'(2'b10) : RESP_OKAY;
    assign r.last  = (rd_beat == rd_q.len);
    assign awready = !wr_data_ph && !wr_resp_ph && stall_cnt[1];
    assign wready  = wr_data_ph && (stall_cnt != 2'b11);
    assign bvalid  = wr_resp_ph;
    assign b       = wr_bad ? resp_t'(2'b10) : RESP_OKAY;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_cnt <= '0;
        end else begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (prepare) begin
            for (int i = 0; i < 1024; i++) begin
                mem[10'(i)] <= data_t'(i << ADDR_LSB) ^ pattern;
            end
        end else if (wvalid && wready) begin
            mem[wr_idx] <= w.data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_q       <= '0;
            wr_q       <= '0;
            rd_beat    <= '0;
            wr_beat    <= '0;
            rd_busy    <= 1'b0;
            rd_bad     <= 1'b0;
            wr_data_ph <= 1'b0;
            wr_resp_ph <= 1'b0;
            wr_bad     <= 1'b0;
            burst_idx  <= 0;
        end else if (prepare) begin
            burst_idx <= 0;
        end else begin
            if (arvalid && arready) begin
                rd_q      <= ar;
                rd_beat   <= '0;
                rd_busy   <= 1'b1;
                rd_bad    <= (burst_idx == fail_burst);
                burst_idx <= burst_idx + 1;
            end else if (rvalid && rready) begin
                rd_beat <= rd_beat + 1'b1;
                if (r.last) begin
                    rd_busy <= 1'b0;
                end
            end
            if (awvalid && awready) begin
                wr_q       <= aw;
                wr_beat    <= '0;
                wr_data_ph <= 1'b1;
                wr_bad     <= (burst_idx == fail_burst);
                burst_idx  <= burst_idx + 1;
            end else if (wvalid && wready) begin
                wr_beat <= wr_beat + 1'b1;
                if (w.last) begin
                    wr_data_ph <= 1'b0;
                    wr_resp_ph <= 1'b1;
                end
            end else if (bvalid && bready) begin
                wr_resp_ph <= 1'b0;
            end
        end
    end

endmodule

//--- verif/axi_dma_asserts.sv
// AXI handshake and status checks, bound onto the DMA top level from the testbench
`timescale 1ns/1ps

module axi_dma_asserts (
    input logic                 clk,
    input logic                 rst_n,
    input dma_pkg::dma_status_t status,
    input dma_pkg::axi_addr_t   ar,
    input logic                 arvalid,
    input logic                 arready,
    input dma_pkg::axi_addr_t   aw,
    input logic                 awvalid,
    input logic                 awready,
    input dma_pkg::axi_w_t      w,
    input logic                 wvalid,
    input logic                 wready
);
    import dma_pkg::*;

    len_t aw_len;
    len_t w_beat;

    // Beat number within the current write burst
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_len <= '0;
            w_beat <= '0;
        end else if (awvalid && awready) begin
            aw_len <= aw.len;
            w_beat <= '0;
        end else if (wvalid && wready) begin
            w_beat <= w_beat + 1'b1;
        end
    end

    ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(ar))
        else $error("AR valid or payload changed before ready");

    aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("AW valid or payload changed before ready");

    w_stable: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("W valid or payload changed before ready");

    done_not_error: assert property (@(posedge clk) disable iff (!rst_n)
        !(status.done && status.error))
        else $error("done and error high together");

    wlast_on_len: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid |-> (w.last == (w_beat == aw_len)))
        else $error("wlast does not match the burst length");

endmodule

//--- verif/tb_axi_dma.sv
// Testbench top: replays the command trace through the DMA engine and checks data, status and memory
`timescale 1ns/1ps

module tb_axi_dma;
    import dma_pkg::*;

    // Read memory holds byte address XOR this
    localparam data_t PATTERN = 32'h5a3c_96e1;

    logic        clk, rst_n, start, prepare;
    dma_cmd_t    cmd;
    dma_status_t status;
    data_t       rd_data, wr_data;
    logic        rd_valid, rd_ready, wr_valid, wr_ready;
    axi_addr_t   ar, aw;
    axi_r_t      r;
    axi_w_t      w;
    resp_t       b;
    logic        arvalid, arready, rvalid, rready;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    int          fail_burst;
    integer      seed;

    axi_dma_top uut (.*);
    axi_slave_model slave (.*, .pattern (PATTERN));
    bind axi_dma_top axi_dma_asserts asserts (.*);

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic abort_with(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_word(input data_t got, input data_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s, expected %h, got %h", $time, what, exp, got);
            stop_run();
        end
    endtask

    task automatic check_status(input dma_status_t got, input dma_status_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s, expected busy %b done %b error %b bytes %0d, got %b %b %b %0d",
                     $time, what, exp.busy, exp.done, exp.error, exp.bytes_xfer,
                     got.busy, got.done, got.error, got.bytes_xfer);
            stop_run();
        end
    endtask

    task automatic check_addr(input axi_addr_t got, input axi_addr_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t: %s, expected addr %h len %0d, got addr %h len %0d",
                     $time, what, exp.addr, exp.len, got.addr, got.len);
            stop_run();
        end
    endtask

    // Burst idx of a transfer of moved beats, cut into full-size bursts
    function automatic axi_addr_t burst_addr(input dma_cmd_t c, input int idx, input int moved);
        axi_addr_t a;
        int        left;
        left   = moved - idx * MAX_BURST_BEATS;
        a.addr = c.addr + addr_t'(idx * MAX_BURST_BEATS * BYTES_PER_BEAT);
        a.len  = len_t'((left > MAX_BURST_BEATS ? MAX_BURST_BEATS : left) - 1);
        return a;
    endfunction

    task automatic run_command(input dma_cmd_t c, input int fail_idx, input bit bp, input int num);
        int          beats;
        int          bursts;
        int          moved;
        int          clean;
        int          got;
        int          sent;
        int          n_addr;
        int          cycles;
        int          rnd;
        int          i;
        bit          finished;
        bit          filled;
        logic [9:0]  widx;
        data_t       wq[$];
        dma_status_t exp_st;
        dma_status_t first_st;
        string       tag;

        tag   = $sformatf("command %0d", num);
        beats = int'(c.length >> ADDR_LSB);
        if (fail_idx >= 0) begin
            bursts = fail_idx + 1;
        end else begin
            bursts = (beats + MAX_BURST_BEATS - 1) / MAX_BURST_BEATS;
        end
        moved = (bursts * MAX_BURST_BEATS < beats) ? bursts * MAX_BURST_BEATS : beats;
        clean = (fail_idx < 0) ? beats : fail_idx * MAX_BURST_BEATS;
        clean = (clean < beats) ? clean : beats;
        exp_st.busy       = 1'b0;
        exp_st.done       = (fail_idx < 0);
        exp_st.error      = (fail_idx >= 0);
        exp_st.bytes_xfer = addr_t'(clean * BYTES_PER_BEAT);
        first_st          = '0;
        first_st.busy     = 1'b1;
        for (i = 0; i < moved; i++) begin
            if (c.mode == MODE_WRITE) begin
                wq.push_back($random(seed));
            end
        end

        // Reseed slave memory and its burst counter
        fail_burst = fail_idx;
        prepare    = 1'b1;
        @(negedge clk);
        prepare = 1'b0;
        cmd     = c;
        start   = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_status(status, first_st, {tag, " status after start"});

        got      = 0;
        sent     = 0;
        n_addr   = 0;
        cycles   = 0;
        finished = 1'b0;
        filled   = 1'b0;
        while (!finished || (c.mode == MODE_READ ? got : sent) < moved) begin
            if (cycles > 4000) begin
                abort_with($sformatf("Timeout: %s did not finish within 4000 cycles", tag));
            end
            if (!finished && !status.busy && (status.done || status.error)) begin
                check_status(status, exp_st, {tag, " final status"});
                finished = 1'b1;
            end
            if ((c.mode == MODE_READ) ? (awvalid && awready) : (arvalid && arready)) begin
                abort_with($sformatf("Address handshake on the wrong channel in %s", tag));
            end
            if ((arvalid && arready) || (awvalid && awready)) begin
                if (n_addr >= bursts) begin
                    abort_with($sformatf("More bursts than expected in %s", tag));
                end
                check_addr(c.mode == MODE_READ ? ar : aw, burst_addr(c, n_addr, moved),
                           {tag, " burst address"});
                n_addr++;
            end
            // Slave waiting on a full read buffer
            if (rvalid && !rready) begin
                filled = 1'b1;
            end
            rnd = $random(seed);
            if (c.mode == MODE_READ) begin
                // Slow core, so the read buffer runs full
                rd_ready = bp ? (rnd[2:0] == 3'b000) : 1'b1;
                if (rd_ready && rd_valid) begin
                    if (got >= moved) begin
                        abort_with($sformatf("Core received an extra word in %s", tag));
                    end
                    check_word(rd_data, (c.addr + addr_t'(got * BYTES_PER_BEAT)) ^ PATTERN,
                               {tag, " read word"});
                    got++;
                end
            end else begin
                wr_valid = (sent < moved) && (bp ? rnd[1] : 1'b1);
                wr_data  = (sent < moved) ? wq[sent] : '0;
                if (wr_valid && wr_ready) begin
                    sent++;
                end
            end
            @(negedge clk);
            cycles++;
        end
        rd_ready = 1'b0;
        wr_valid = 1'b0;
        if (rd_valid) begin
            abort_with($sformatf("Read buffer still holds data after %s", tag));
        end
        if (c.mode == MODE_READ && bp && moved > FIFO_DEPTH && !filled) begin
            abort_with($sformatf("Read buffer never filled under back-pressure in %s", tag));
        end
        if (n_addr != bursts) begin
            abort_with($sformatf("%s issued %0d bursts instead of %0d", tag, n_addr, bursts));
        end
        for (i = 0; i < sent; i++) begin
            widx = c.addr[11:2] + 10'(i);
            check_word(slave.mem[widx], wq[i], {tag, " memory word"});
        end
    endtask

    initial begin
        int       fd;
        int       n;
        int       count;
        int       mode_i;
        int       len_i;
        int       fail_i;
        int       bp_i;
        addr_t    a;
        dma_cmd_t c;
        string    line;

        seed       = 3397;
        rst_n      = 1'b0;
        start      = 1'b0;
        prepare    = 1'b0;
        cmd        = '0;
        rd_ready   = 1'b0;
        wr_valid   = 1'b0;
        wr_data    = '0;
        fail_burst = -1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("verif/dma_trace.txt", "r");
        if (fd == 0) begin
            abort_with("Cannot open the trace file verif/dma_trace.txt");
        end
        count = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() == 0 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%d %h %d %d %d", mode_i, a, len_i, fail_i, bp_i);
            if (n <= 0) begin
                continue;
            end
            if (n != 5) begin
                abort_with($sformatf("Malformed trace line: %s", line));
            end
            c.mode   = dma_mode_t'(mode_i);
            c.addr   = a;
            c.length = addr_t'(len_i);
            run_command(c, fail_i, bp_i != 0, count);
            count++;
        end
        $fclose(fd);
        if (count == 0) begin
            abort_with("The trace file holds no commands");
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- verif/dma_trace.txt
# mode (0 read, 1 write), address (hex), length in bytes, failing burst (-1 none),
# core back-pressure (0 off, 1 on)
0 00000100 200 -1 0
1 00000400 136 -1 0
0 00000200 200 -1 1
1 00000600 136 -1 1
1 00000800 136 1 0
1 00000900 64 -1 0
0 00000a00 200 0 0
0 00000b00 40 -1 0
0 00000c00 0 -1 0
1 00000d00 0 -1 0

//--- compile.f
src/dma_pkg.sv
src/dma_fifo.sv
src/dma_controller.sv
src/axi_read_master.sv
src/axi_write_master.sv
src/axi_dma_top.sv
verif/axi_slave_model.sv
verif/axi_dma_asserts.sv
verif/tb_axi_dma.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_axi_dma -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/Vtb_axi_dma)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1
